//--- pcPkg.sv
package pcPkg;

  //////////////////////////////////////////////////////////////////////
  // word geometry
  //////////////////////////////////////////////////////////////////////

  // every uplink word is code then payload
  localparam int codeWidth = 8;
  localparam int dataWidth = 24;

  // route prefix used by the board routing fabric
  localparam int routeWidth = 10;

  //////////////////////////////////////////////////////////////////////
  // word codes and routes
  //////////////////////////////////////////////////////////////////////

  // BD words use codes 0 to 12, one per funnel leaf
  localparam logic [codeWidth-1:0] bdLeafMax = 8'd12;

  // FPGA-generated words share the same code space
  localparam logic [codeWidth-1:0] codeFiltEvent = 8'd13;
  localparam logic [codeWidth-1:0] codeHeartbeat = 8'd14;

  // all-zero route sends the word up to the PC
  localparam logic [routeWidth-1:0] goHomeRoute = '0;

  //////////////////////////////////////////////////////////////////////
  // event and heartbeat fields
  //////////////////////////////////////////////////////////////////////

  // state is the DSP accumulator width
  localparam int stateWidth = 27;
  // filter index takes the bits left over in the second word
  localparam int filtIdxWidth = 21;
  localparam int timeWidth = 48;

  typedef struct packed {
    logic [codeWidth-1:0] code;
    logic [dataWidth-1:0] payload;
  } pcWordT;

  typedef struct packed {
    logic [routeWidth-1:0] route;
    pcWordT                word;
  } routedWordT;

  typedef struct packed {
    logic [filtIdxWidth-1:0] filtIdx;
    logic [stateWidth-1:0]   state;
  } filtEventT;

endpackage

//--- wordSlot.sv
`timescale 1ns/1ps

module wordSlot #(
  parameter type payloadT = logic [31:0]
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    inV,
  input  payloadT inData,
  output logic    inA,
  output logic    outV,
  output payloadT outData,
  input  logic    outA
);

  // held low for one cycle after reset, then always high
  logic    readyQ;
  // second entry, only filled while the head is stalled
  logic    skidV;
  payloadT skidData;
  logic    inTake;
  logic    outTake;

  // ack depends only on local state, no path from outA
  assign inA = readyQ & ~skidV;
  assign inTake = inV & inA;
  assign outTake = outV & outA;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      readyQ <= 1'b0;
      outV <= 1'b0;
      skidV <= 1'b0;
    end else begin
      readyQ <= 1'b1;
      if (!outV || outTake) begin
        // head is free, refill from skid first, else from input
        outV <= skidV | inTake;
        skidV <= 1'b0;
      end else if (inTake) begin
        // head stalled, park the new word
        skidV <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!outV || outTake) begin
      outData <= skidV ? skidData : inData;
    end else if (inTake) begin
      skidData <= inData;
    end
  end

  // a stalled head word must not change under the receiver
  assert property (@(posedge clk) disable iff (!rstN)
    outV && !outA |=> outV && $stable(outData));

endmodule

//--- bdSerializer.sv
`timescale 1ns/1ps

module bdSerializer #(
  parameter int BdPayloadWidth = 48
) (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        bdV,
  input  logic [pcPkg::codeWidth-1:0] bdCode,
  input  logic [BdPayloadWidth-1:0]   bdPayload,
  output logic                        bdA,
  output logic                        wordV,
  output pcPkg::pcWordT               word,
  output logic                        last,
  input  logic                        wordA
);

  // number of 24-bit chunks per packet
  localparam int nChunks = BdPayloadWidth / pcPkg::dataWidth;
  localparam int countWidth = (nChunks > 1) ? $clog2(nChunks) : 1;

  logic [BdPayloadWidth-1:0]   shiftQ;
  logic [pcPkg::codeWidth-1:0] codeQ;
  logic [countWidth-1:0]       count;
  logic                        accept;
  logic                        take;

  assign accept = bdV & bdA;
  assign take = wordV & wordA;

  // lowest chunk always sits at the bottom of the shifter
  assign word = {codeQ, shiftQ[pcPkg::dataWidth-1:0]};
  assign last = (count == countWidth'(nChunks - 1));

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      bdA <= 1'b0;
      wordV <= 1'b0;
      count <= '0;
    end else if (accept) begin
      // first chunk valid next cycle, input closed until done
      bdA <= 1'b0;
      wordV <= 1'b1;
      count <= '0;
    end else if (take) begin
      if (last) begin
        wordV <= 1'b0;
        bdA <= 1'b1;
      end
      count <= count + 1'b1;
    end else if (!wordV) begin
      // idle, open the packet input
      bdA <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      shiftQ <= bdPayload;
      codeQ <= bdCode;
    end else if (take) begin
      // LSB chunk first, next chunk drops into place
      shiftQ <= shiftQ >> pcPkg::dataWidth;
    end
  end

  // the chip funnel only has leaves 0 to 12
  assert property (@(posedge clk) disable iff (!rstN)
    accept |-> bdCode <= pcPkg::bdLeafMax);

endmodule

//--- fpgaSerializer.sv
`timescale 1ns/1ps

module fpgaSerializer (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         evV,
  input  pcPkg::filtEventT             evData,
  output logic                         evA,
  input  logic                         hbTick,
  input  logic [pcPkg::timeWidth-1:0]  hbTime,
  output logic                         wordV,
  output pcPkg::pcWordT                word,
  output logic                         last,
  input  logic                         wordA
);

  // buffered event stream
  logic                        evBufV;
  pcPkg::filtEventT            evBufData;
  logic                        evBufA;

  // heartbeat waiting for a group boundary
  logic                        hbPend;
  logic [pcPkg::timeWidth-1:0] hbTimeQ;
  logic                        hbAvail;
  logic [pcPkg::timeWidth-1:0] hbTimeSel;

  // upper word of the pair in flight
  logic [pcPkg::dataWidth-1:0] hiData;
  // 0 while the first word is out, 1 for the second
  logic                        phase;
  logic                        boundary;
  logic                        loadHb;
  logic                        loadEv;

  wordSlot #(
    .payloadT(pcPkg::filtEventT)
  ) evSlot_inst (
    .clk(clk),
    .rstN(rstN),
    .inV(evV),
    .inData(evData),
    .inA(evA),
    .outV(evBufV),
    .outData(evBufData),
    .outA(evBufA)
  );

  //////////////////////////////////////////////////////////////////////
  // group selection
  //////////////////////////////////////////////////////////////////////

  // output empty or second word leaving this cycle
  assign boundary = ~wordV | (wordA & phase);

  // a tick this cycle counts as pending, its time wins
  assign hbAvail = hbTick | hbPend;
  assign hbTimeSel = hbTick ? hbTime : hbTimeQ;

  // heartbeat before event
  assign loadHb = boundary & hbAvail;
  assign loadEv = boundary & ~hbAvail & evBufV;
  assign evBufA = boundary & ~hbAvail;

  assign last = phase;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wordV <= 1'b0;
      phase <= 1'b0;
      hbPend <= 1'b0;
    end else begin
      if (boundary) begin
        wordV <= loadHb | loadEv;
        phase <= 1'b0;
      end else if (wordA) begin
        phase <= 1'b1;
      end
      if (loadHb) begin
        hbPend <= 1'b0;
      end else if (hbTick) begin
        hbPend <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // word formatting
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // newer tick replaces a pending time
    if (hbTick) begin
      hbTimeQ <= hbTime;
    end
    if (loadHb) begin
      word <= {pcPkg::codeHeartbeat, hbTimeSel[pcPkg::dataWidth-1:0]};
      hiData <= hbTimeSel[pcPkg::timeWidth-1:pcPkg::dataWidth];
    end else if (loadEv) begin
      word <= {pcPkg::codeFiltEvent, evBufData.state[pcPkg::dataWidth-1:0]};
      // filter index sits above the top state bits
      hiData <= {evBufData.filtIdx,
                 evBufData.state[pcPkg::stateWidth-1:pcPkg::dataWidth]};
    end else if (wordV && wordA && !phase) begin
      word.payload <= hiData;
    end
  end

  // first word taken means second word follows with the same code
  assert property (@(posedge clk) disable iff (!rstN)
    wordV && wordA && !last |=> wordV && last && $stable(word.code));

endmodule

//--- pcPacker.sv
`timescale 1ns/1ps

module pcPacker (
  input  logic              clk,
  input  logic              rstN,
  input  logic              bdWordV,
  input  pcPkg::pcWordT     bdWord,
  input  logic              bdLast,
  output logic              bdWordA,
  input  logic              fpgaWordV,
  input  pcPkg::pcWordT     fpgaWord,
  input  logic              fpgaLast,
  output logic              fpgaWordA,
  input  logic              globalV,
  input  pcPkg::routedWordT globalWord,
  output logic              globalA,
  output logic              pcV,
  output pcPkg::routedWordT pcWord,
  input  logic              pcA
);

  // source indices
  localparam logic [1:0] srcBd = 2'd0;
  localparam logic [1:0] srcFpga = 2'd1;
  localparam logic [1:0] srcGlobal = 2'd2;

  logic [2:0]        srcV;
  logic [2:0]        srcLast;
  pcPkg::routedWordT srcWord [3];

  // last source served, held while its group is open
  logic [1:0]        curSrc;
  logic              locked;
  logic [1:0]        pick;
  logic              pickV;
  logic [1:0]        sel;
  logic              selV;
  logic              slotInA;
  logic              take;

  // local streams get the go-home route, global words keep theirs
  assign srcWord[srcBd] = {pcPkg::goHomeRoute, bdWord};
  assign srcWord[srcFpga] = {pcPkg::goHomeRoute, fpgaWord};
  assign srcWord[srcGlobal] = globalWord;

  assign srcV = {globalV, fpgaWordV, bdWordV};
  // global words are single-word groups
  assign srcLast = {1'b1, fpgaLast, bdLast};

  //////////////////////////////////////////////////////////////////////
  // round-robin pick
  //////////////////////////////////////////////////////////////////////

  always_comb begin : rrPick
    logic [1:0] idx;
    pick = curSrc;
    pickV = 1'b0;
    // search starts at the source after the last one served
    for (int k = 1; k <= 3; k++) begin
      idx = 2'((int'(curSrc) + k) % 3);
      if (!pickV && srcV[idx]) begin
        pick = idx;
        pickV = 1'b1;
      end
    end
  end

  // open group stays on its source
  assign sel = locked ? curSrc : pick;
  assign selV = locked ? srcV[curSrc] : pickV;
  assign take = selV & slotInA;

  assign bdWordA = take & (sel == srcBd);
  assign fpgaWordA = take & (sel == srcFpga);
  assign globalA = take & (sel == srcGlobal);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      // BD gets the first turn
      curSrc <= srcGlobal;
      locked <= 1'b0;
    end else if (take) begin
      curSrc <= sel;
      locked <= ~srcLast[sel];
    end
  end

  wordSlot #(
    .payloadT(pcPkg::routedWordT)
  ) outSlot_inst (
    .clk(clk),
    .rstN(rstN),
    .inV(selV),
    .inData(srcWord[sel]),
    .inA(slotInA),
    .outV(pcV),
    .outData(pcWord),
    .outA(pcA)
  );

  assert property (@(posedge clk) disable iff (!rstN)
    $onehot0({bdWordA, fpgaWordA, globalA}));

  // no other source slips into an open group
  assert property (@(posedge clk) disable iff (!rstN)
    take && !srcLast[sel] |=> !take || sel == $past(sel));

endmodule

//--- pcUplink.sv
`timescale 1ns/1ps

module pcUplink #(
  parameter int BdPayloadWidth = 48
) (
  input  logic                        clk,
  input  logic                        rstN,
  // BD packets from the chip funnel
  input  logic                        bdV,
  input  logic [pcPkg::codeWidth-1:0] bdCode,
  input  logic [BdPayloadWidth-1:0]   bdPayload,
  output logic                        bdA,
  // filtered spike events
  input  logic                        evV,
  input  pcPkg::filtEventT            evData,
  output logic                        evA,
  // heartbeat from the time manager
  input  logic                        hbTick,
  input  logic [pcPkg::timeWidth-1:0] hbTime,
  // already-routed board words
  input  logic                        globalV,
  input  pcPkg::routedWordT           globalWord,
  output logic                        globalA,
  // to the PC link
  output logic                        pcV,
  output pcPkg::routedWordT           pcWord,
  input  logic                        pcA
);

  // serializer to packer streams
  logic          bdWordV;
  pcPkg::pcWordT bdWord;
  logic          bdLast;
  logic          bdWordA;
  logic          fpgaWordV;
  pcPkg::pcWordT fpgaWord;
  logic          fpgaLast;
  logic          fpgaWordA;

  bdSerializer #(
    .BdPayloadWidth(BdPayloadWidth)
  ) bdSerializer_inst (
    .clk(clk),
    .rstN(rstN),
    .bdV(bdV),
    .bdCode(bdCode),
    .bdPayload(bdPayload),
    .bdA(bdA),
    .wordV(bdWordV),
    .word(bdWord),
    .last(bdLast),
    .wordA(bdWordA)
  );

  fpgaSerializer fpgaSerializer_inst (
    .clk(clk),
    .rstN(rstN),
    .evV(evV),
    .evData(evData),
    .evA(evA),
    .hbTick(hbTick),
    .hbTime(hbTime),
    .wordV(fpgaWordV),
    .word(fpgaWord),
    .last(fpgaLast),
    .wordA(fpgaWordA)
  );

  pcPacker pcPacker_inst (
    .clk(clk),
    .rstN(rstN),
    .bdWordV(bdWordV),
    .bdWord(bdWord),
    .bdLast(bdLast),
    .bdWordA(bdWordA),
    .fpgaWordV(fpgaWordV),
    .fpgaWord(fpgaWord),
    .fpgaLast(fpgaLast),
    .fpgaWordA(fpgaWordA),
    .globalV(globalV),
    .globalWord(globalWord),
    .globalA(globalA),
    .pcV(pcV),
    .pcWord(pcWord),
    .pcA(pcA)
  );

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int halfPeriodNs = 5
) (
  output logic clk
);

  // free-running clock, 10 ns period with the default half period
  initial begin
    clk = 1'b0;
    forever begin
      #halfPeriodNs clk = ~clk;
    end
  end

endmodule

//--- pcUplinkTb.sv
`timescale 1ns/1ps

module pcUplinkTb;

  localparam int bdWidth = 48;
  // cycles allowed for one handshake, and for the output to drain
  localparam int ackLimit = 200;
  localparam int drainLimit = 4000;

  logic                        clk;
  logic                        rstN;
  logic                        bdV;
  logic [pcPkg::codeWidth-1:0] bdCode;
  logic [bdWidth-1:0]          bdPayload;
  logic                        bdA;
  logic                        evV;
  pcPkg::filtEventT            evData;
  logic                        evA;
  logic                        hbTick;
  logic [pcPkg::timeWidth-1:0] hbTime;
  logic                        globalV;
  pcPkg::routedWordT           globalWord;
  logic                        globalA;
  logic                        pcV;
  pcPkg::routedWordT           pcWord;
  logic                        pcA;
  // random back-pressure on the PC side
  logic                        stallOn;

  // expected words per source, oldest first
  pcPkg::routedWordT expBd[$];
  pcPkg::pcWordT     expFpga[$];
  pcPkg::routedWordT expGlobal[$];
  // source with a half-sent two-word group, -1 if none
  int                openSrc = -1;
  int                valueErrors = 0;
  int                otherErrors = 0;

  tbClock clock_inst (.clk(clk));

  pcUplink #(
    .BdPayloadWidth(bdWidth)
  ) pcUplink_inst (
    .clk(clk),
    .rstN(rstN),
    .bdV(bdV),
    .bdCode(bdCode),
    .bdPayload(bdPayload),
    .bdA(bdA),
    .evV(evV),
    .evData(evData),
    .evA(evA),
    .hbTick(hbTick),
    .hbTime(hbTime),
    .globalV(globalV),
    .globalWord(globalWord),
    .globalA(globalA),
    .pcV(pcV),
    .pcWord(pcWord),
    .pcA(pcA)
  );

  //////////////////////////////////////////////////////////////////////
  // output checking
  //////////////////////////////////////////////////////////////////////

  task automatic compareRouted(input string name, input pcPkg::routedWordT got,
                               input pcPkg::routedWordT exp);
    if (got !== exp) begin
      valueErrors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compareWord(input string name, input pcPkg::pcWordT got,
                             input pcPkg::pcWordT exp);
    if (got !== exp) begin
      valueErrors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  // route picks global, code splits BD from FPGA words
  task automatic sortWord(input pcPkg::routedWordT w);
    int src;
    if (w.route != pcPkg::goHomeRoute) src = 2;
    else if (w.word.code <= pcPkg::bdLeafMax) src = 0;
    else src = 1;
    if (openSrc >= 0 && src != openSrc) begin
      otherErrors++;
      $display("word from source %0d broke into a group of source %0d", src, openSrc);
    end
    if (src == 0 && expBd.size() > 0) compareRouted("pcWord bd", w, expBd.pop_front());
    else if (src == 1 && expFpga.size() > 0) compareWord("pcWord fpga", w.word,
                                                          expFpga.pop_front());
    else if (src == 2 && expGlobal.size() > 0) compareRouted("pcWord global", w,
                                                              expGlobal.pop_front());
    else begin
      otherErrors++;
      $display("output word %h was not expected", w);
    end
    // local groups are two words, global words stand alone
    if (src == 2 || openSrc == src) openSrc = -1;
    else openSrc = src;
  endtask

  // mid-cycle sample, transfer happens on the next rising edge
  always @(negedge clk) begin
    if (rstN && pcV && pcA) begin
      sortWord(pcWord);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic abortRun(input string why);
    $display("timed out: %s", why);
    $display("Errors: value %0d, other %0d", valueErrors, otherErrors + 1);
    $display("Simulation failed");
    $finish;
  endtask

  function automatic logic ackOf(input int src);
    case (src)
      0: return bdA;
      1: return evA;
      default: return globalA;
    endcase
  endfunction

  // returns 1 ns after the edge that took the word
  task automatic waitAck(input int src, input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (!ackOf(src)) begin
      if (n == ackLimit) abortRun({"no acknowledge on ", name});
      n++;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic sendBd(input logic [pcPkg::codeWidth-1:0] code,
                        input logic [bdWidth-1:0] payload);
    // LSB chunk first, every chunk keeps the packet code
    for (int i = 0; i < bdWidth / pcPkg::dataWidth; i++) begin
      expBd.push_back({pcPkg::goHomeRoute, code,
                       payload[i*pcPkg::dataWidth +: pcPkg::dataWidth]});
    end
    bdV = 1'b1;
    bdCode = code;
    bdPayload = payload;
    waitAck(0, "bdA");
    bdV = 1'b0;
  endtask

  task automatic sendGlobal(input pcPkg::routedWordT w);
    expGlobal.push_back(w);
    globalV = 1'b1;
    globalWord = w;
    waitAck(2, "globalA");
    globalV = 1'b0;
  endtask

  // state low bits, then filter index over the top three state bits
  function automatic void expectEvent(input pcPkg::filtEventT e);
    expFpga.push_back({pcPkg::codeFiltEvent, e.state[23:0]});
    expFpga.push_back({pcPkg::codeFiltEvent, e.filtIdx, e.state[26:24]});
  endfunction

  task automatic driveEvent(input pcPkg::filtEventT e);
    evV = 1'b1;
    evData = e;
    waitAck(1, "evA");
    evV = 1'b0;
  endtask

  task automatic sendEvent(input pcPkg::filtEventT e);
    expectEvent(e);
    driveEvent(e);
  endtask

  function automatic void expectHeartbeat(input logic [pcPkg::timeWidth-1:0] t);
    expFpga.push_back({pcPkg::codeHeartbeat, t[23:0]});
    expFpga.push_back({pcPkg::codeHeartbeat, t[47:24]});
  endfunction

  // one-cycle tick, no acknowledge
  task automatic pulseTick(input logic [pcPkg::timeWidth-1:0] t);
    hbTick = 1'b1;
    hbTime = t;
    @(posedge clk);
    #1;
    hbTick = 1'b0;
  endtask

  function automatic pcPkg::filtEventT randomEvent();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return pcPkg::filtEventT'(r[47:0]);
  endfunction

  // nonzero route keeps global words apart from the go-home streams
  function automatic pcPkg::routedWordT randomGlobal();
    return pcPkg::routedWordT'({10'($urandom_range(1, 1023)), $urandom});
  endfunction

  task automatic sendRandomBd();
    logic [63:0] r;
    r = {$urandom, $urandom};
    sendBd(8'($urandom_range(0, 12)), r[47:0]);
  endtask

  task automatic randomGap();
    repeat ($urandom_range(0, 3)) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic stallLoop();
    forever begin
      @(posedge clk);
      #1;
      pcA = stallOn ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  endtask

  // wait for every expected word, then idle to catch duplicates
  task automatic drain();
    int n;
    n = 0;
    while (expBd.size() + expFpga.size() + expGlobal.size() != 0) begin
      if (n == drainLimit) abortRun("expected words never reached the output");
      n++;
      @(posedge clk);
    end
    repeat (20) @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic testBdPacket();
    sendBd(8'd5, 48'h123456_abcdef);
    sendBd(pcPkg::bdLeafMax, 48'hfedcba_987654);
    sendBd(8'd0, 48'h000001_800000);
    drain();
  endtask

  task automatic testFilteredEvent();
    sendEvent(pcPkg::filtEventT'(48'h1a2b3c_4d5e6f));
    sendEvent(pcPkg::filtEventT'(48'hffffff_000000));
    drain();
  endtask

  task automatic testHeartbeat();
    expectHeartbeat(48'h0badc0_ffee11);
    pulseTick(48'h0badc0_ffee11);
    drain();
    // event already waits in the input buffer when the tick lands
    // both are pending at the same boundary and the heartbeat pair goes first
    expectHeartbeat(48'h123abc_456def);
    expectEvent(pcPkg::filtEventT'(48'h55aa55_aa55aa));
    fork
      begin
        @(posedge clk);
        #1;
        pulseTick(48'h123abc_456def);
      end
      driveEvent(pcPkg::filtEventT'(48'h55aa55_aa55aa));
    join
    drain();
  endtask

  task automatic testGlobalPass();
    repeat (4) sendGlobal(randomGlobal());
    drain();
  endtask

  // all three sources at once, optionally with PC back-pressure
  task automatic testRandomMix(input int n, input logic stall);
    stallOn = stall;
    fork
      repeat (n) begin
        randomGap();
        sendRandomBd();
      end
      repeat (n) begin
        randomGap();
        sendEvent(randomEvent());
      end
      repeat (n) begin
        randomGap();
        sendGlobal(randomGlobal());
      end
    join
    drain();
    stallOn = 1'b0;
  endtask

  initial begin
    void'($urandom(32'hf2e7_f248));
    rstN = 1'b0;
    bdV = 1'b0;
    bdCode = '0;
    bdPayload = '0;
    evV = 1'b0;
    evData = '0;
    hbTick = 1'b0;
    hbTime = '0;
    globalV = 1'b0;
    globalWord = '0;
    pcA = 1'b1;
    stallOn = 1'b0;
    fork
      stallLoop();
    join_none
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    testBdPacket();
    testFilteredEvent();
    testHeartbeat();
    testGlobalPass();
    testRandomMix(40, 1'b0);
    testRandomMix(40, 1'b1);
    $display("Errors: value %0d, other %0d", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- pcUplink.f
pcPkg.sv
wordSlot.sv
bdSerializer.sv
fpgaSerializer.sv
pcPacker.sv
pcUplink.sv
tbClock.sv
pcUplinkTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# build and run the pcUplink testbench with Verilator

cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert -j 0 --top-module pcUplinkTb \
  -f pcUplink.f -o pcUplinkSim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/pcUplinkSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulator exited with status $simStatus"
  exit 1
fi

if grep -q "Simulation failed" "$logFile"; then
  exit 1
fi
exit 0
